/* source/sched_pkg.sv */
package sched_pkg;

  // ------------------------------
  // carousel positions
  // ------------------------------
  typedef logic [7:0] slot_t;   // fast carousel position
  typedef logic [3:0] frame_t;  // frame carousel position, odd = refresh
  typedef logic [2:0] stream_t;

  localparam int NUM_STREAMS = 8;

  // the two fast opportunities within one fast revolution
  localparam slot_t FAST_SLOT_A = 8'd0;
  localparam slot_t FAST_SLOT_B = 8'd96;

  // even frames 0..10 carry the six slow streams
  localparam frame_t SLOW_FRAME_LAST = 4'd10;

  localparam stream_t STREAM_FAST_A = 3'd6;  // owns slot A outside slow frames
  localparam stream_t STREAM_FAST_B = 3'd7;  // always owns slot B

  // ------------------------------
  // opportunity strobe
  // ------------------------------
  typedef struct packed {
    logic    fast_hit;     // transfer opportunity
    logic    refresh_hit;  // refresh opportunity, odd frames only
    stream_t stream;       // owner of the opportunity
  } opportunity_t;

endpackage

/* source/xfer_pkg.sv */
package xfer_pkg;

  // ------------------------------
  // DRAM transfer address
  // ------------------------------
  localparam logic [12:0] PAGE_BYTES = 13'h1000;  // 4 KiB page

  typedef struct packed {
    logic [19:0] page;
    logic [11:0] offset;
  } xfer_page_t;

  // same word seen flat (mailbox) or split (sequencer)
  typedef union packed {
    logic [31:0] word;
    xfer_page_t  po;
  } xfer_addr_u;

  // ------------------------------
  // dispatcher <-> sequencer
  // ------------------------------
  typedef struct packed {
    xfer_addr_u  start;
    logic [5:0]  length;   // bytes requested
    logic [1:0]  section;  // switch section
  } block_cmd_t;

  typedef struct packed {
    xfer_addr_u  old_addr;     // address reached
    logic [5:0]  count_sent;
    logic        end_of_page;  // block clipped at page end and fully sent
  } block_rpt_t;

  // one mailbox access, same layout for both ports
  typedef struct packed {
    logic        read;
    logic        write;
    logic [2:0]  addr;
    logic [31:0] data;
  } mbox_req_t;

  // toward the external block mover
  typedef struct packed {
    logic [11:0] start;      // offset inside the aligned page
    logic [5:0]  count_req;
    logic [1:0]  section;
    logic        issue;      // one-cycle pulse
  } mover_cmd_t;

endpackage

/* source/slot_carousel.sv */
module slot_carousel #(
  parameter int SLOT_LAST = 191
) (
  input  logic                    CLK,
  input  logic                    RST,
  output sched_pkg::opportunity_t opportunity
);
  import sched_pkg::*;

  slot_t        fast_pos;
  frame_t       frame_pos;
  logic         fast_wrap;
  logic         at_slot_a;
  logic         at_slot_b;
  logic         refresh_frame;
  logic         slow_frame;
  opportunity_t opp_next;

  assign fast_wrap     = fast_pos == slot_t'(SLOT_LAST);
  assign at_slot_a     = fast_pos == FAST_SLOT_A;
  assign at_slot_b     = fast_pos == FAST_SLOT_B;
  assign refresh_frame = frame_pos[0];
  assign slow_frame    = !frame_pos[0] && (frame_pos <= SLOW_FRAME_LAST);

  // ------------------------------
  // opportunity decode
  // ------------------------------
  always_comb
  begin
    opp_next.fast_hit    = at_slot_a || at_slot_b;
    opp_next.refresh_hit = at_slot_a && refresh_frame;  // first hit of the frame
    if (at_slot_b)
      opp_next.stream = STREAM_FAST_B;
    else if (slow_frame)
      opp_next.stream = frame_pos[3:1];  // frame halved
    else
      opp_next.stream = STREAM_FAST_A;
  end

  // ------------------------------
  // counters
  // ------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      // out of bounds, first hit comes after the counter wraps
      fast_pos    <= slot_t'(SLOT_LAST + 2);
      frame_pos   <= 4'd3;
      opportunity <= '0;
    end
    else
    begin
      if (fast_wrap)
      begin
        fast_pos  <= '0;
        frame_pos <= frame_pos + 4'd1;
      end
      else
        fast_pos <= fast_pos + 8'd1;

      opportunity <= opp_next;  // one-cycle strobe
    end
  end

  // strobes only ever come from the two fast positions
  a_hit_position : assert property (@(posedge CLK) disable iff (!RST)
    (opportunity.fast_hit || opportunity.refresh_hit) |->
      ($past(fast_pos) == FAST_SLOT_A || $past(fast_pos) == FAST_SLOT_B));

endmodule

/* source/transfer_dispatcher.sv */
module transfer_dispatcher #(
  parameter int BLOCK_LENGTH = 63
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  sched_pkg::opportunity_t opportunity,
  output xfer_pkg::mbox_req_t     mbox_req,
  input  xfer_pkg::xfer_addr_u    mbox_rdata,
  output logic                    go,
  output xfer_pkg::block_cmd_t    cmd,
  input  logic                    ready,
  input  xfer_pkg::block_rpt_t    rpt,
  output logic                    refresh_strobe
);
  import sched_pkg::*;
  import xfer_pkg::*;

  logic [1:0] trans_req;
  logic [1:0] trans_ack;
  logic [1:0] refresh_req;
  logic [1:0] refresh_ack;
  stream_t    queue [4];  // owner per outstanding opportunity
  stream_t    cur_stream;
  logic       busy;
  logic [1:0] rd_pipe;    // mailbox read in flight
  logic       ready_prev;

  logic       ready_rise;
  logic       trans_pending;
  logic       refresh_pending;
  logic       can_start;
  logic       start_read;
  logic       exec_refresh;
  logic       write_back;
  logic       reissue;
  logic       load_cmd;
  xfer_addr_u new_addr;
  logic [5:0] new_len;

  assign ready_rise      = ready && !ready_prev;
  assign trans_pending   = trans_req != trans_ack;
  assign refresh_pending = refresh_req != refresh_ack;

  assign can_start    = ready && !busy && !go && !ready_rise;
  assign exec_refresh = can_start && refresh_pending;  // refresh wins
  assign start_read   = can_start && trans_pending && !refresh_pending;

  assign write_back = ready_rise && busy;
  assign reissue    = write_back && rpt.end_of_page;
  assign load_cmd   = rd_pipe[1] || reissue;

  // continue from the page boundary, or start from the mailbox word
  assign new_addr = reissue ? rpt.old_addr : mbox_rdata;
  assign new_len  = reissue ? cmd.length - rpt.count_sent : 6'(BLOCK_LENGTH);

  // ------------------------------
  // mailbox port
  // ------------------------------
  always_comb
  begin
    mbox_req       = '0;
    mbox_req.read  = start_read;
    mbox_req.write = write_back;
    mbox_req.addr  = write_back ? cur_stream : queue[trans_ack];
    mbox_req.data  = rpt.old_addr.word;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      trans_req      <= '0;
      trans_ack      <= '0;
      refresh_req    <= '0;
      refresh_ack    <= '0;
      cur_stream     <= '0;
      busy           <= 1'b0;
      rd_pipe        <= '0;
      ready_prev     <= 1'b1;
      go             <= 1'b0;
      cmd            <= '0;
      refresh_strobe <= 1'b0;
    end
    else
    begin
      ready_prev <= ready;
      rd_pipe    <= {rd_pipe[0], start_read};

      // queue opportunities as counter mismatches
      if (opportunity.fast_hit)
      begin
        queue[trans_req] <= opportunity.stream;
        trans_req        <= trans_req + 2'd1;  // wraps when full
      end
      if (opportunity.refresh_hit)
        refresh_req <= refresh_req + 2'd1;

      if (start_read)
      begin
        cur_stream <= queue[trans_ack];
        trans_ack  <= trans_ack + 2'd1;
        busy       <= 1'b1;
      end
      else if (write_back && !rpt.end_of_page)
        busy <= 1'b0;  // transfer complete

      if (exec_refresh)
      begin
        refresh_strobe <= ~refresh_strobe;
        refresh_ack    <= refresh_ack + 2'd1;
      end

      if (load_cmd)
      begin
        cmd.start   <= new_addr;
        cmd.length  <= new_len;
        cmd.section <= cur_stream[1:0];
      end

      // go held until the sequencer drops ready
      if (load_cmd)
        go <= 1'b1;
      else if (!ready)
        go <= 1'b0;
    end
  end

  a_go_when_ready : assert property (@(posedge CLK) disable iff (!RST)
    $rose(go) |-> ready);

endmodule

/* source/block_sequencer.sv */
module block_sequencer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 go,
  input  xfer_pkg::block_cmd_t cmd,
  output logic                 ready,
  output xfer_pkg::block_rpt_t rpt,
  output xfer_pkg::mover_cmd_t mover,
  input  logic [5:0]           blck_count_sent,
  input  logic                 blck_working,
  output logic [19:0]          page_addr,
  output logic                 request_align,
  input  logic                 grant_align
);
  import xfer_pkg::*;

  // one-hot state bits, shifted left on each step
  localparam int ST_LATCH = 0;
  localparam int ST_SIZE  = 1;
  localparam int ST_WAIT  = 2;
  localparam int ST_IDLE  = 3;

  logic [3:0]  state;
  logic        working_prev;
  logic [1:0]  issue_op;      // toggle pair
  logic        issued;
  logic        clipped;
  logic [11:0] blk_start;
  logic [5:0]  blk_len;
  logic [5:0]  blk_count;
  logic [1:0]  blk_section;

  logic        do_go;
  logic        done;
  logic        step;
  logic        can_issue;
  logic [12:0] end_addr;
  logic [12:0] rest_of_page;
  logic        crosses;

  assign ready = state[ST_IDLE];
  assign do_go = go && state[ST_IDLE];
  assign done  = state[ST_WAIT] && working_prev && !blck_working;  // falling edge
  assign step  = do_go || state[ST_LATCH] || state[ST_SIZE] || done;

  assign end_addr     = {1'b0, blk_start} + 13'(blk_len);
  assign crosses      = end_addr > PAGE_BYTES;
  assign rest_of_page = PAGE_BYTES - {1'b0, blk_start};

  assign can_issue = request_align && grant_align && !issued && !blck_working &&
                     !working_prev && (state[ST_SIZE] || state[ST_WAIT]);

  always_comb
  begin
    mover.start     = blk_start;
    mover.count_req = blk_count;
    mover.section   = blk_section;
    mover.issue     = issue_op[0] ^ issue_op[1];
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state         <= 4'b1000;  // idle
      working_prev  <= 1'b0;
      issue_op      <= '0;
      issued        <= 1'b0;
      clipped       <= 1'b0;
      request_align <= 1'b0;
      page_addr     <= '0;
      blk_start     <= '0;
      blk_len       <= '0;
      blk_count     <= '0;
      blk_section   <= '0;
      rpt           <= '0;
    end
    else
    begin
      working_prev <= blck_working;

      if (step)
        state <= {state[2:0], do_go};

      // ------------------------------
      // latch: split address, ask for alignment
      // ------------------------------
      if (state[ST_LATCH])
      begin
        request_align <= 1'b1;
        page_addr     <= cmd.start.po.page;
        blk_start     <= cmd.start.po.offset;
        blk_len       <= cmd.length;
        blk_section   <= cmd.section;
        issued        <= 1'b0;
      end

      // size: clip to the bytes left in the page
      if (state[ST_SIZE])
      begin
        clipped   <= crosses;
        blk_count <= crosses ? rest_of_page[5:0] : blk_len;
      end

      if (can_issue)
      begin
        issue_op[0] <= ~issue_op[0];
        issued      <= 1'b1;
      end
      issue_op[1] <= issue_op[0];

      // ------------------------------
      // completion report
      // ------------------------------
      if (done)
      begin
        request_align       <= 1'b0;
        rpt.old_addr.word   <= {page_addr, blk_start} + 32'(blck_count_sent);
        rpt.count_sent      <= blck_count_sent;
        rpt.end_of_page     <= clipped && (blk_count == blck_count_sent);
      end
    end
  end

  a_state_onehot : assert property (@(posedge CLK) disable iff (!RST)
    $onehot(state));

endmodule

/* source/transfer_mailbox.sv */
module transfer_mailbox (
  input  logic                 CLK,
  input  logic                 RST,
  input  xfer_pkg::mbox_req_t  int_req,
  output xfer_pkg::xfer_addr_u int_rdata,
  input  xfer_pkg::mbox_req_t  cpu_req,
  output logic [31:0]          cpu_rdata,
  output logic                 cpu_read_ack,
  output logic                 cpu_write_ack
);
  import sched_pkg::*;
  import xfer_pkg::*;

  xfer_addr_u  mem [NUM_STREAMS];
  logic [2:0]  read_addr;    // shared by both ports
  logic        int_read_r;

  logic        cpu_rd;
  logic        cpu_wr;
  logic        we;
  logic [2:0]  write_addr;
  logic [31:0] write_data;
  xfer_addr_u  rd_word;

  assign rd_word = mem[read_addr];

  // internal port first, ack pulse blocks a CPU repeat
  assign cpu_rd = cpu_req.read && !(int_req.read || cpu_read_ack);
  assign cpu_wr = cpu_req.write && !(int_req.write || cpu_write_ack);

  assign we         = int_req.write || cpu_wr;
  assign write_addr = int_req.write ? int_req.addr : cpu_req.addr;
  assign write_data = int_req.write ? int_req.data : cpu_req.data;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < NUM_STREAMS; i++)
        mem[i] <= '0;
      read_addr     <= '0;
      int_read_r    <= 1'b0;
      int_rdata     <= '0;
      cpu_rdata     <= '0;
      cpu_read_ack  <= 1'b0;
      cpu_write_ack <= 1'b0;
    end
    else
    begin
      // ------------------------------
      // reads, data one cycle after ack
      // ------------------------------
      if (int_read_r)
        int_rdata <= rd_word;
      if (cpu_read_ack)
        cpu_rdata <= rd_word.word;

      int_read_r   <= int_req.read;
      cpu_read_ack <= cpu_rd;

      if (int_req.read)
        read_addr <= int_req.addr;
      else if (cpu_rd)
        read_addr <= cpu_req.addr;

      // writes
      if (we)
        mem[write_addr].word <= write_data;
      cpu_write_ack <= cpu_wr;
    end
  end

  a_read_ports_exclusive : assert property (@(posedge CLK) disable iff (!RST)
    !(cpu_read_ack && int_read_r));

endmodule

/* source/hyper_scheduler.sv */
module hyper_scheduler #(
  parameter int SLOT_LAST    = 191,
  parameter int BLOCK_LENGTH = 63
) (
  input  logic                 CLK,
  input  logic                 RST,
  // cpu mailbox port
  input  xfer_pkg::mbox_req_t  cpu_req,
  output logic [31:0]          cpu_rdata,
  output logic                 cpu_read_ack,
  output logic                 cpu_write_ack,
  // block mover
  output xfer_pkg::mover_cmd_t mover,
  input  logic [5:0]           blck_count_sent,
  input  logic                 blck_working,
  // memory controller
  output logic [19:0]          page_addr,
  output logic                 request_align,
  input  logic                 grant_align,
  output logic                 refresh_strobe
);
  import sched_pkg::*;
  import xfer_pkg::*;

  opportunity_t opportunity;
  mbox_req_t    mbox_req;
  xfer_addr_u   mbox_rdata;
  logic         go;
  logic         ready;
  block_cmd_t   cmd;
  block_rpt_t   rpt;

  // ------------------------------
  // decode
  // ------------------------------
  slot_carousel #(
    .SLOT_LAST (SLOT_LAST)
  ) i_carousel (
    .CLK         (CLK),
    .RST         (RST),
    .opportunity (opportunity)
  );

  // execute
  transfer_dispatcher #(
    .BLOCK_LENGTH (BLOCK_LENGTH)
  ) i_dispatcher (
    .CLK            (CLK),
    .RST            (RST),
    .opportunity    (opportunity),
    .mbox_req       (mbox_req),
    .mbox_rdata     (mbox_rdata),
    .go             (go),
    .cmd            (cmd),
    .ready          (ready),
    .rpt            (rpt),
    .refresh_strobe (refresh_strobe)
  );

  block_sequencer i_sequencer (
    .CLK             (CLK),
    .RST             (RST),
    .go              (go),
    .cmd             (cmd),
    .ready           (ready),
    .rpt             (rpt),
    .mover           (mover),
    .blck_count_sent (blck_count_sent),
    .blck_working    (blck_working),
    .page_addr       (page_addr),
    .request_align   (request_align),
    .grant_align     (grant_align)
  );

  // result
  transfer_mailbox i_mailbox (
    .CLK           (CLK),
    .RST           (RST),
    .int_req       (mbox_req),
    .int_rdata     (mbox_rdata),
    .cpu_req       (cpu_req),
    .cpu_rdata     (cpu_rdata),
    .cpu_read_ack  (cpu_read_ack),
    .cpu_write_ack (cpu_write_ack)
  );

endmodule

/* testbench/tb_hyper_scheduler.sv */
module tb_hyper_scheduler;
  import sched_pkg::*;
  import xfer_pkg::*;

  localparam int SLOT_LAST       = 15;  // short frames
  localparam int BLOCK_LENGTH    = 63;
  localparam int RESET_CYCLES    = 8;
  localparam int FRAME_CYCLES    = SLOT_LAST + 1;
  localparam int LEAD_IN         = 256;  // fast counter starts out of bounds
  localparam int NUM_TESTS       = 6;
  localparam int POLL_CYCLES     = 20 * FRAME_CYCLES;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + LEAD_IN +
                                   (NUM_TESTS + 16) * 2 * FRAME_CYCLES;
  localparam logic [31:0] COLLIDE_WORD = 32'h0000_0A5C;

  typedef struct packed {
    stream_t    stream;
    xfer_addr_u start;
    xfer_addr_u reached;
  } table_entry_t;

  logic        CLK;
  logic        RST;
  mbox_req_t   cpu_req;
  logic [31:0] cpu_rdata;
  logic        cpu_read_ack;
  logic        cpu_write_ack;
  mover_cmd_t  mover;
  logic [5:0]  blck_count_sent;
  logic        blck_working;
  logic [19:0] page_addr;
  logic        request_align;
  logic        grant_align;
  logic        refresh_strobe;

  table_entry_t stim [NUM_TESTS];
  int           n_pass = 0;
  int           n_fail = 0;
  int           cycle = 0;
  int           work_left = 0;
  logic [19:0]  done_page;
  logic [19:0]  issue_page [$];   // per issue pulse
  logic [11:0]  issue_start [$];
  logic [5:0]   issue_count [$];
  event         block_done;

  // carousel reference for refresh counting
  slot_t        model_fast;
  frame_t       model_frame;
  int           model_hits;
  int           refresh_toggles;
  logic         strobe_prev;

  hyper_scheduler #(
    .SLOT_LAST    (SLOT_LAST),
    .BLOCK_LENGTH (BLOCK_LENGTH)
  ) i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .cpu_req         (cpu_req),
    .cpu_rdata       (cpu_rdata),
    .cpu_read_ack    (cpu_read_ack),
    .cpu_write_ack   (cpu_write_ack),
    .mover           (mover),
    .blck_count_sent (blck_count_sent),
    .blck_working    (blck_working),
    .page_addr       (page_addr),
    .request_align   (request_align),
    .grant_align     (grant_align),
    .refresh_strobe  (refresh_strobe)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK)
    cycle <= cycle + 1;

  // ------------------------------
  // mover and controller models
  // ------------------------------
  always @(posedge CLK)
  begin
    if (!RST)
    begin
      blck_working    <= 1'b0;
      blck_count_sent <= '0;
      work_left = 0;
    end
    else if (work_left > 0)
    begin
      work_left = work_left - 1;
      if (work_left == 0)
      begin
        blck_working <= 1'b0;
        -> block_done;
      end
    end
    else if (mover.issue)
    begin
      if (!request_align)
      begin
        n_fail++;
        $display("issue pulse seen without an alignment request");
      end
      blck_working    <= 1'b1;
      blck_count_sent <= mover.count_req;  // whole request sent
      work_left = 2 + int'($urandom % 5);
      done_page = page_addr;
      issue_page.push_back(page_addr);
      issue_start.push_back(mover.start);
      issue_count.push_back(mover.count_req);
    end
  end

  always @(posedge CLK)
    grant_align <= RST ? request_align : 1'b0;  // one cycle behind

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      model_fast      <= slot_t'(SLOT_LAST + 2);
      model_frame     <= 4'd3;
      model_hits      <= 0;
      refresh_toggles <= 0;
      strobe_prev     <= 1'b0;
    end
    else
    begin
      if (model_fast == slot_t'(SLOT_LAST))
      begin
        model_fast  <= '0;
        model_frame <= model_frame + 4'd1;
      end
      else
        model_fast <= model_fast + 8'd1;
      if (model_fast == 8'd0 && model_frame[0])
        model_hits <= model_hits + 1;  // odd frame
      strobe_prev <= refresh_strobe;
      if (refresh_strobe != strobe_prev)
        refresh_toggles <= refresh_toggles + 1;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_addr(input string name, input xfer_addr_u exp, input xfer_addr_u act);
    if (act.word === exp.word)
    begin
      n_pass++;
      $display("PASS %s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s expected %h actual %h", name, exp.word, act.word);
    end
  endtask

  task automatic check_page(input string name, input logic [19:0] exp, input logic [19:0] act);
    if (act === exp)
    begin
      n_pass++;
      $display("PASS %s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [5:0] exp, input logic [5:0] act);
    if (act === exp)
    begin
      n_pass++;
      $display("PASS %s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_refresh(input string name, input int exp, input int act);
    if (act == exp)
    begin
      n_pass++;
      $display("PASS %s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act == exp)
    begin
      n_pass++;
      $display("PASS %s", name);
    end
    else
    begin
      n_fail++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // ------------------------------
  // cpu port
  // ------------------------------
  task automatic cpu_write(input stream_t addr, input logic [31:0] data, output int latency);
    int waited;
    waited = 0;
    @(posedge CLK);
    cpu_req.write <= 1'b1;
    cpu_req.addr  <= addr;
    cpu_req.data  <= data;
    do
    begin
      @(posedge CLK);
      waited++;
    end while (!cpu_write_ack && waited < POLL_CYCLES);
    cpu_req.write <= 1'b0;  // held until acknowledged
    latency = waited;
    if (!cpu_write_ack)
    begin
      n_fail++;
      $display("mailbox write to word %0d was never acknowledged", addr);
    end
  endtask

  task automatic cpu_read(input stream_t addr, output logic [31:0] data, output int latency);
    int waited;
    waited = 0;
    @(posedge CLK);
    cpu_req.read <= 1'b1;
    cpu_req.addr <= addr;
    do
    begin
      @(posedge CLK);
      waited++;
    end while (!cpu_read_ack && waited < POLL_CYCLES);
    cpu_req.read <= 1'b0;
    latency = waited;
    if (!cpu_read_ack)
    begin
      n_fail++;
      $display("mailbox read of word %0d was never acknowledged", addr);
    end
    @(posedge CLK);
    data = cpu_rdata;  // one cycle after the ack
  endtask

  // poll one stream's word until its transfer is written back
  task automatic wait_for_word(input stream_t s, input xfer_addr_u exp, output xfer_addr_u act);
    int          start_cycle;
    int          lat;
    logic [31:0] rd;
    start_cycle = cycle;
    do
    begin
      cpu_read(s, rd, lat);
      act.word = rd;
    end while (rd !== exp.word && cycle - start_cycle < POLL_CYCLES);
  endtask

  task automatic check_split(input table_entry_t e);
    int          idx;
    logic [12:0] left;
    xfer_addr_u  first;
    xfer_addr_u  next;
    xfer_addr_u  boundary;
    idx  = -1;
    left = PAGE_BYTES - {1'b0, e.start.po.offset};  // bytes to page end
    for (int i = 0; i < issue_page.size(); i++)
      if (idx < 0 && issue_page[i] == e.start.po.page)
        idx = i;
    if (idx < 0 || idx + 1 >= issue_page.size())
    begin
      n_fail++;
      $display("no split block pair was issued for stream %0d", e.stream);
    end
    else
    begin
      first.word         = {issue_page[idx], issue_start[idx]};
      next.word          = {issue_page[idx + 1], issue_start[idx + 1]};
      boundary.po.page   = e.start.po.page + 20'd1;  // follow-up starts on the next page
      boundary.po.offset = '0;
      check_addr($sformatf("stream %0d first start", e.stream), e.start, first);
      check_count($sformatf("stream %0d clipped count", e.stream), left[5:0], issue_count[idx]);
      check_page($sformatf("stream %0d next page", e.stream), e.start.po.page + 20'd1,
                 issue_page[idx + 1]);
      check_addr($sformatf("stream %0d follow-up start", e.stream), boundary, next);
      check_count($sformatf("stream %0d rest count", e.stream),
                  6'(BLOCK_LENGTH) - left[5:0], issue_count[idx + 1]);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    table_entry_t e;
    xfer_addr_u   got;
    xfer_addr_u   want;
    logic [31:0]  rd;
    int           lat;
    int           n_blocks;
    int           waited;
    logic         found;

    RST             = 1'b0;
    cpu_req         = '0;
    blck_working    = 1'b0;
    blck_count_sent = '0;
    grant_align     = 1'b0;
    void'($urandom(37));

    // in hit order: frames 4, 6, 8, 10, then 0 and 2 after the wrap
    stim[0] = {3'd2, 32'h0001_0100, 32'h0001_013F};
    stim[1] = {3'd3, 32'h0002_0A00, 32'h0002_0A3F};
    stim[2] = {3'd4, 32'h0003_0FEC, 32'h0003_102B};  // crosses
    stim[3] = {3'd5, 32'h0004_0FC1, 32'h0004_1000};  // ends on the boundary
    stim[4] = {3'd0, 32'h0005_0FFF, 32'h0005_103E};  // one byte left
    stim[5] = {3'd1, 32'h0006_0000, 32'h0006_003F};

    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b1;

    // stream 7 stays idle until the lead-in passes slot B
    cpu_write(3'd7, 32'h1234_5678, lat);
    check_cycles("cpu write ack latency", 2, lat);
    cpu_read(3'd7, rd, lat);
    check_cycles("cpu read ack latency", 2, lat);
    got.word  = rd;
    want.word = 32'h1234_5678;
    check_addr("cpu readback", want, got);

    for (int i = 0; i < NUM_TESTS; i++)
      cpu_write(stim[i].stream, stim[i].start.word, lat);

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      e = stim[i];
      wait_for_word(e.stream, e.reached, got);
      check_addr($sformatf("stream %0d reached", e.stream), e.reached, got);
      if ({1'b0, e.start.po.offset} + 13'(BLOCK_LENGTH) > PAGE_BYTES)
        check_split(e);
    end

    // sample late in an even frame, all refreshes done by then
    waited = 0;
    do
    begin
      @(posedge CLK);
      waited++;
    end while (!(!model_frame[0] && model_fast == slot_t'(SLOT_LAST - 1) && model_hits >= 4)
               && waited < POLL_CYCLES);
    check_refresh("refresh toggles", model_hits, refresh_toggles);

    // stream 6 blocks run on page 0
    found    = 1'b0;
    n_blocks = 0;
    while (!found && n_blocks < 8)
    begin
      @(block_done);
      n_blocks++;
      found = done_page == 20'd0;
    end
    if (!found)
    begin
      n_fail++;
      $display("no stream 6 block completed for the collision test");
    end
    else
    begin
      cpu_write(3'd6, COLLIDE_WORD, lat);  // lands on the write-back cycle
      check_cycles("cpu write behind write-back", 3, lat);
      cpu_read(3'd6, rd, lat);
      got.word  = rd;
      want.word = COLLIDE_WORD;
      check_addr("cpu overwrite", want, got);
    end

    $display("%0d checks passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* filelist.f */
source/sched_pkg.sv
source/xfer_pkg.sv
source/slot_carousel.sv
source/transfer_dispatcher.sv
source/block_sequencer.sv
source/transfer_mailbox.sv
source/hyper_scheduler.sv
testbench/tb_hyper_scheduler.sv

/* Makefile */
# Verilator build and run of the scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_hyper_scheduler
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
